//--- sources.f
+incdir+include
rtl/hanoi_display_pkg.sv
rtl/text_layer.sv
rtl/disk_layer.sv
rtl/line_compositor.sv
rtl/hanoi_line_render.sv
verification/line_checker.sv
verification/hanoi_line_render_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f sources.f \
	--top-module hanoi_line_render_tb \
	-o hanoi_sim

./obj_dir/hanoi_sim | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

//--- verification/hanoi_line_render_tb.sv
`default_nettype none

module hanoi_line_render_tb;

localparam int clk_period = 100;
localparam int drive_delay = 10;
localparam int quiet_rows = 20;
localparam int text_scenes = 4;
localparam int stack_scenes = 2;
localparam int burst_rows = 64;
localparam int gap_rows = 40;
localparam int max_gap = 5;
// From the top of slot 9 down to the bottom of slot 0
localparam int band_first = hanoi_display_pkg::disk_base_y -
	(hanoi_display_pkg::disks_per_peg - 1) * hanoi_display_pkg::disk_pitch;
localparam int band_last = hanoi_display_pkg::disk_base_y + hanoi_display_pkg::disk_h - 1;
localparam int total_rows = 2 + quiet_rows + text_scenes * hanoi_display_pkg::glyph_h +
	stack_scenes * (band_last - band_first + 1) + burst_rows + gap_rows;
localparam int watchdog_cycles = total_rows + gap_rows * max_gap + 6 * 10 + 100;

logic clk = 1'b0;
logic reset;
logic row_valid;
logic [hanoi_display_pkg::row_w-1:0] row;
hanoi_display_pkg::scene_t scene;
wire line_valid;
wire hanoi_display_pkg::line_t line;
logic test_done;
logic run_done;
int error_count;
int check_count;

always #(clk_period / 2) clk = ~clk;

hanoi_line_render hanoi_line_render_inst
(
	.clk(clk),
	.reset(reset),
	.row_valid(row_valid),
	.row(row),
	.scene(scene),
	.line_valid(line_valid),
	.line(line)
);

line_checker line_checker_inst
(
	.clk(clk),
	.reset(reset),
	.row_valid(row_valid),
	.row(row),
	.scene(scene),
	.line_valid(line_valid),
	.line(line),
	.test_done(test_done),
	.run_done(run_done),
	.error_count(error_count),
	.check_count(check_count)
);

//////////////////////////////
// Stimulus helpers
task automatic step_to_drive();
	@(posedge clk);
	#drive_delay;
endtask

task automatic send_row(input int r, input hanoi_display_pkg::scene_t s);
	step_to_drive();
	row_valid = 1'b1;
	row = 10'(r);
	scene = s;
endtask

task automatic idle(input int n);
	repeat (n)
	begin
		step_to_drive();
		row_valid = 1'b0;
	end
endtask

task automatic end_test();
	idle(4);
	step_to_drive();
	test_done = 1'b1;
	step_to_drive();
	test_done = 1'b0;
endtask

// Stacks shrink upward with empty slots above the top disk
function automatic hanoi_display_pkg::scene_t random_scene();
	hanoi_display_pkg::scene_t s;
	int slot;
	s = '0;
	for (int i = 0; i < 4; i++)
	begin
		s.time_digits[i] = 4'($urandom_range(9, 0));
		s.move_digits[i] = 4'($urandom_range(9, 0));
	end
	for (int p = 0; p < hanoi_display_pkg::peg_count; p++)
	begin
		slot = 0;
		for (int size = hanoi_display_pkg::disks_per_peg; size >= 1; size--)
			if ($urandom_range(1, 0) == 1)
			begin
				s.pegs[p][slot] = 4'(size);
				slot++;
			end
	end
	return s;
endfunction

function automatic int quiet_row();
	int r;
	r = $urandom_range(hanoi_display_pkg::screen_h - 2, 1);
	while ((r >= hanoi_display_pkg::text_top &&
		r < hanoi_display_pkg::text_top + hanoi_display_pkg::glyph_h) ||
		(r >= band_first && r <= band_last &&
		(r - band_first) % hanoi_display_pkg::disk_pitch < hanoi_display_pkg::disk_h))
		r = $urandom_range(hanoi_display_pkg::screen_h - 2, 1);
	return r;
endfunction

//////////////////////////////
initial
begin
	hanoi_display_pkg::scene_t s;
	void'($urandom(57393));
	reset = 1'b1;
	row_valid = 1'b0;
	row = '0;
	scene = '0;
	test_done = 1'b0;
	run_done = 1'b0;
	repeat (2) @(posedge clk);
	#drive_delay;
	reset = 1'b0;

	// Quiet after reset before the full border rows
	idle(5);
	send_row(0, random_scene());
	send_row(hanoi_display_pkg::screen_h - 1, random_scene());
	end_test();

	repeat (quiet_rows)
		send_row(quiet_row(), random_scene());
	end_test();

	repeat (text_scenes)
	begin
		s = random_scene();
		for (int r = hanoi_display_pkg::text_top;
			r < hanoi_display_pkg::text_top + hanoi_display_pkg::glyph_h; r++)
			send_row(r, s);
	end
	end_test();

	repeat (stack_scenes)
	begin
		s = random_scene();
		for (int r = band_first; r <= band_last; r++)
			send_row(r, s);
	end
	end_test();

	// Back to back with a new scene each cycle
	repeat (burst_rows)
		send_row($urandom_range(hanoi_display_pkg::screen_h - 1, 0), random_scene());
	end_test();

	repeat (gap_rows)
	begin
		send_row($urandom_range(hanoi_display_pkg::screen_h - 1, 0), random_scene());
		idle($urandom_range(max_gap, 0));
	end
	end_test();

	step_to_drive();
	run_done = 1'b1;
	step_to_drive();
	run_done = 1'b0;
	if (error_count == 0 && check_count == total_rows)
		$display("RESULT: PASS");
	else
	begin
		if (check_count != total_rows)
			$display("%0d lines checked where %0d rows were requested",
				check_count, total_rows);
		$display("RESULT: FAIL");
	end
	$finish;
end

initial
begin
	#(watchdog_cycles * clk_period);
	$display("timeout: run did not finish within %0d clock cycles", watchdog_cycles);
	$display("RESULT: FAIL");
	$finish;
end

endmodule

`default_nettype wire

//--- verification/line_checker.sv
`default_nettype none

`include "glyph_font.svh"

module line_checker
(
	input wire clk,
	input wire reset,
	input wire row_valid,
	input wire logic [hanoi_display_pkg::row_w-1:0] row,
	input wire hanoi_display_pkg::scene_t scene,
	input wire line_valid,
	input wire hanoi_display_pkg::line_t line,
	input wire test_done,
	input wire run_done,
	output int error_count,
	output int check_count
);

typedef struct packed
{
	int due;
	int row_num;
	hanoi_display_pkg::line_t line;
} expect_t;

expect_t pending [$];
int cyc = 0;
int errors = 0;
int checks = 0;
int test_num = 1;
int test_checks = 0;
int test_errors = 0;
logic seen_line = 1'b0;

assign error_count = errors;
assign check_count = checks;

//////////////////////////////
// Reference model
function automatic hanoi_display_pkg::line_t glyph_pixels(
	input hanoi_display_pkg::line_t l,
	input int x,
	input logic [4:0] code,
	input int prow
);
	hanoi_display_pkg::line_t res;
	logic [17:0] pat;
	res = l;
	pat = glyph_font[code];
	for (int col = 0; col < hanoi_display_pkg::glyph_w; col++)
		if (pat[17 - 3 * prow - col / hanoi_display_pkg::glyph_scale])
			res[x + col] = 1'b1;
	return res;
endfunction

function automatic hanoi_display_pkg::line_t model_line(
	input int r,
	input hanoi_display_pkg::scene_t s
);
	hanoi_display_pkg::line_t l;
	logic [4:0] time_label [5];
	logic [4:0] move_label [5];
	int prow;
	int ofs;
	int sz;
	l = '0;
	time_label = '{g_t, g_i, g_m, g_e, g_colon};
	move_label = '{g_m, g_o, g_v, g_e, g_colon};
	if (r == 0 || r == hanoi_display_pkg::screen_h - 1)
		l = '1;
	else
	begin
		l[0] = 1'b1;
		l[hanoi_display_pkg::screen_w - 1] = 1'b1;
	end
	if (r >= hanoi_display_pkg::text_top &&
		r < hanoi_display_pkg::text_top + hanoi_display_pkg::glyph_h)
	begin
		prow = (r - hanoi_display_pkg::text_top) / hanoi_display_pkg::glyph_scale;
		for (int n = 0; n < 5; n++)
		begin
			l = glyph_pixels(l, hanoi_display_pkg::time_label_x +
				n * hanoi_display_pkg::glyph_pitch, time_label[n], prow);
			l = glyph_pixels(l, hanoi_display_pkg::move_label_x +
				n * hanoi_display_pkg::glyph_pitch, move_label[n], prow);
		end
		for (int i = 0; i < 4; i++)
		begin
			l = glyph_pixels(l, hanoi_display_pkg::time_digit_x[i],
				{1'b0, s.time_digits[i]}, prow);
			l = glyph_pixels(l, hanoi_display_pkg::move_digit_x[i],
				{1'b0, s.move_digits[i]}, prow);
		end
		l = glyph_pixels(l, hanoi_display_pkg::time_colon_x, g_colon, prow);
	end
	// Disk of size s covers 100-10s to 99+10s inside its peg column
	for (int p = 0; p < hanoi_display_pkg::peg_count; p++)
		for (int k = 0; k < hanoi_display_pkg::disks_per_peg; k++)
		begin
			ofs = r - (hanoi_display_pkg::disk_base_y - k * hanoi_display_pkg::disk_pitch);
			sz = int'(s.pegs[p][k]);
			if (sz != 0 && ofs >= 1 && ofs <= hanoi_display_pkg::disk_h - 2)
				for (int x = 100 - 10 * sz; x <= 99 + 10 * sz; x++)
					l[hanoi_display_pkg::peg_x[p] + x] = 1'b1;
		end
	return l;
endfunction

function automatic int first_diff(
	input hanoi_display_pkg::line_t a,
	input hanoi_display_pkg::line_t b
);
	for (int i = 0; i < hanoi_display_pkg::screen_w; i++)
		if (a[i] !== b[i])
			return i;
	return -1;
endfunction

task automatic note_error();
	errors++;
	test_errors++;
endtask

//////////////////////////////
// Comparison, one line due 2 cycles after its row
always @(posedge clk)
begin
	expect_t head;
	cyc++;
	if (!reset)
	begin
		if (line_valid)
		begin
			seen_line = 1'b1;
			if (pending.size() == 0)
			begin
				$display("line_valid high at time %0t with no row pending", $time);
				note_error();
			end
			else
			begin
				head = pending.pop_front();
				checks++;
				test_checks++;
				if (head.due != cyc)
				begin
					$display("line for row %0d arrived at time %0t, %0d cycles off its slot",
						head.row_num, $time, cyc - head.due);
					note_error();
				end
				else if (line !== head.line)
				begin
					$display("mismatch at time %0t: row %0d, first wrong column %0d",
						$time, head.row_num, first_diff(line, head.line));
					note_error();
				end
			end
		end
		else if (pending.size() != 0 && pending[0].due <= cyc)
		begin
			head = pending.pop_front();
			$display("line for row %0d never arrived, line_valid low at time %0t",
				head.row_num, $time);
			note_error();
		end
		else if (!seen_line && line !== '0)
		begin
			$display("line register not cleared by reset at time %0t", $time);
			seen_line = 1'b1;
			note_error();
		end
		if (row_valid)
			pending.push_back('{due: cyc + 2, row_num: int'(row),
				line: model_line(int'(row), scene)});
	end
	if (test_done)
	begin
		$display("test %0d done: %0d lines checked, %0d errors",
			test_num, test_checks, test_errors);
		test_num++;
		test_checks = 0;
		test_errors = 0;
	end
	if (run_done)
	begin
		if (pending.size() != 0)
		begin
			$display("%0d requested lines still outstanding at the end", pending.size());
			note_error();
		end
		$display("tests %0d, lines checked %0d, errors %0d", test_num - 1, checks, errors);
	end
end

endmodule

`default_nettype wire

//--- rtl/hanoi_line_render.sv
`default_nettype none

module hanoi_line_render
(
	input wire clk,
	input wire reset,
	input wire row_valid,
	input wire logic [hanoi_display_pkg::row_w-1:0] row,
	input wire hanoi_display_pkg::scene_t scene,
	output wire logic line_valid,
	output wire hanoi_display_pkg::line_t line
);

wire logic text_valid;
wire hanoi_display_pkg::line_t text_line;
wire logic disk_valid;
wire hanoi_display_pkg::line_t disk_line;

//////////////////////////////
// Stage one, both layers side by side
text_layer text_layer_inst
(
	.clk(clk),
	.reset(reset),
	.row_valid(row_valid),
	.row(row),
	.scene(scene),
	.text_valid(text_valid),
	.text_line(text_line)
);

disk_layer disk_layer_inst
(
	.clk(clk),
	.reset(reset),
	.row_valid(row_valid),
	.row(row),
	.scene(scene),
	.disk_valid(disk_valid),
	.disk_line(disk_line)
);

// Stage two
line_compositor line_compositor_inst
(
	.clk(clk),
	.reset(reset),
	.row_valid(row_valid),
	.row(row),
	.text_valid(text_valid),
	.text_line(text_line),
	.disk_valid(disk_valid),
	.disk_line(disk_line),
	.line_valid(line_valid),
	.line(line)
);

endmodule

`default_nettype wire

//--- rtl/line_compositor.sv
`default_nettype none

module line_compositor
(
	input wire clk,
	input wire reset,
	input wire row_valid,
	input wire logic [hanoi_display_pkg::row_w-1:0] row,
	input wire text_valid,
	input wire hanoi_display_pkg::line_t text_line,
	input wire disk_valid,
	input wire hanoi_display_pkg::line_t disk_line,
	output logic line_valid,
	output hanoi_display_pkg::line_t line
);

logic row_valid_d;
logic [hanoi_display_pkg::row_w-1:0] row_d;
hanoi_display_pkg::line_t border;

// Row follows the layers by one cycle
always_ff @(posedge clk)
	row_d <= row;

always_comb
begin
	border = '0;
	if (row_d == '0 || int'(row_d) == hanoi_display_pkg::screen_h - 1)
		border = '1;
	else
	begin
		border[0] = 1'b1;
		border[hanoi_display_pkg::screen_w-1] = 1'b1;
	end
end

//////////////////////////////
always_ff @(posedge clk)
begin
	if (reset)
	begin
		row_valid_d <= 1'b0;
		line_valid <= 1'b0;
		line <= '0;
	end
	else
	begin
		row_valid_d <= row_valid;
		line_valid <= row_valid_d;
		if (row_valid_d)
			line <= border | text_line | disk_line;
	end
end

// Both layers and the border must describe the same row
assert property (@(posedge clk) disable iff (reset)
	(text_valid == disk_valid) && (disk_valid == row_valid_d));

endmodule

`default_nettype wire

//--- rtl/disk_layer.sv
`default_nettype none

module disk_layer
(
	input wire clk,
	input wire reset,
	input wire row_valid,
	input wire logic [hanoi_display_pkg::row_w-1:0] row,
	input wire hanoi_display_pkg::scene_t scene,
	output logic disk_valid,
	output hanoi_display_pkg::line_t disk_line
);

hanoi_display_pkg::disk_size_t [hanoi_display_pkg::peg_count-1:0] hit_size;
logic [hanoi_display_pkg::peg_count*hanoi_display_pkg::disks_per_peg-1:0] size_ok;
hanoi_display_pkg::line_t disk_next;

//////////////////////////////
// Size of the disk whose band covers this row, per peg
// Band rows 0 and 19 stay dark to split stacked disks
always_comb
begin
	int ofs;
	for (int p = 0; p < hanoi_display_pkg::peg_count; p++)
	begin
		hit_size[p] = '0;
		for (int k = 0; k < hanoi_display_pkg::disks_per_peg; k++)
		begin
			ofs = int'(row) - (hanoi_display_pkg::disk_base_y - k * hanoi_display_pkg::disk_pitch);
			if (ofs >= 1 && ofs <= hanoi_display_pkg::disk_h - 2)
				hit_size[p] = scene.pegs[p][k];
		end
	end
end

// Size s spans 20*s pixels centered in the peg column
always_comb
begin
	int half;
	disk_next = '0;
	for (int p = 0; p < hanoi_display_pkg::peg_count; p++)
	begin
		half = int'(hit_size[p]) *
			(hanoi_display_pkg::disk_w / 2 / hanoi_display_pkg::disks_per_peg);
		for (int x = 0; x < hanoi_display_pkg::disk_w; x++)
			if (x >= hanoi_display_pkg::disk_w / 2 - half && x < hanoi_display_pkg::disk_w / 2 + half)
				disk_next[hanoi_display_pkg::peg_x[p] + x] = 1'b1;
	end
end

always_comb
begin
	for (int p = 0; p < hanoi_display_pkg::peg_count; p++)
		for (int k = 0; k < hanoi_display_pkg::disks_per_peg; k++)
			size_ok[p * hanoi_display_pkg::disks_per_peg + k] = scene.pegs[p][k] <= 4'd10;
end

always_ff @(posedge clk)
begin
	if (reset)
	begin
		disk_valid <= 1'b0;
		disk_line <= '0;
	end
	else
	begin
		disk_valid <= row_valid;
		if (row_valid)
			disk_line <= disk_next;
	end
end

// Wider disks would spill into the next peg column
assert property (@(posedge clk) disable iff (reset) row_valid |-> &size_ok);

endmodule

`default_nettype wire

//--- rtl/text_layer.sv
`default_nettype none

`include "glyph_font.svh"

module text_layer
(
	input wire clk,
	input wire reset,
	input wire row_valid,
	input wire logic [hanoi_display_pkg::row_w-1:0] row,
	input wire hanoi_display_pkg::scene_t scene,
	output logic text_valid,
	output hanoi_display_pkg::line_t text_line
);

int row_ofs;
logic in_band;
logic [2:0] pat_row;
logic [7:0] digit_ok;
hanoi_display_pkg::line_t text_next;

// Paints one pattern row of a glyph at column x
function automatic hanoi_display_pkg::line_t put_glyph(
	input hanoi_display_pkg::line_t acc,
	input int x,
	input logic [4:0] code,
	input logic [2:0] prow
);
	logic [17:0] bits;
	logic [2:0] trip;
	hanoi_display_pkg::line_t res;
	bits = glyph_font[code];
	trip = bits[15 - 3 * int'(prow) +: 3];
	res = acc;
	for (int c = 0; c < hanoi_display_pkg::glyph_w / hanoi_display_pkg::glyph_scale; c++)
		for (int k = 0; k < hanoi_display_pkg::glyph_scale; k++)
			res[x + c * hanoi_display_pkg::glyph_scale + k] = trip[2 - c];
	return res;
endfunction

assign row_ofs = int'(row) - hanoi_display_pkg::text_top;
assign in_band = (row_ofs >= 0) && (row_ofs < hanoi_display_pkg::glyph_h);
assign pat_row = 3'(row_ofs / hanoi_display_pkg::glyph_scale);

//////////////////////////////
always_comb
begin
	text_next = '0;
	if (in_band)
	begin
		text_next = put_glyph(text_next, hanoi_display_pkg::time_label_x, g_t, pat_row);
		text_next = put_glyph(text_next, hanoi_display_pkg::time_label_x + 14, g_i, pat_row);
		text_next = put_glyph(text_next, hanoi_display_pkg::time_label_x + 28, g_m, pat_row);
		text_next = put_glyph(text_next, hanoi_display_pkg::time_label_x + 42, g_e, pat_row);
		text_next = put_glyph(text_next, hanoi_display_pkg::time_label_x + 56, g_colon, pat_row);
		// MOVE label, same spacing
		for (int n = 0; n < 5; n++)
			text_next = put_glyph(text_next,
				hanoi_display_pkg::move_label_x + n * hanoi_display_pkg::glyph_pitch,
				(n == 0) ? g_m : (n == 1) ? g_o : (n == 2) ? g_v : (n == 3) ? g_e : g_colon,
				pat_row);
		for (int i = 0; i < 4; i++)
		begin
			text_next = put_glyph(text_next, hanoi_display_pkg::time_digit_x[i],
				{1'b0, scene.time_digits[i]}, pat_row);
			text_next = put_glyph(text_next, hanoi_display_pkg::move_digit_x[i],
				{1'b0, scene.move_digits[i]}, pat_row);
		end
		text_next = put_glyph(text_next, hanoi_display_pkg::time_colon_x, g_colon, pat_row);
	end
end

always_comb
begin
	for (int i = 0; i < 4; i++)
	begin
		digit_ok[i] = scene.time_digits[i] <= 4'd9;
		digit_ok[4 + i] = scene.move_digits[i] <= 4'd9;
	end
end

always_ff @(posedge clk)
begin
	if (reset)
	begin
		text_valid <= 1'b0;
		text_line <= '0;
	end
	else
	begin
		text_valid <= row_valid;
		if (row_valid)
			text_line <= text_next;
	end
end

// The glyph table has no entries past 9 for digits
assert property (@(posedge clk) disable iff (reset) row_valid |-> &digit_ok);

endmodule

`default_nettype wire

//--- rtl/hanoi_display_pkg.sv
`default_nettype none

package hanoi_display_pkg;

//////////////////////////////
// Screen geometry
localparam int screen_w = 640;
localparam int screen_h = 480;
localparam int row_w = 10;

//////////////////////////////
// Text band
localparam int glyph_w = 12;
localparam int glyph_h = 24;
// One pattern cell becomes a 4x4 block
localparam int glyph_scale = 4;
localparam int text_top = 10;
localparam int time_label_x = 10;
localparam int move_label_x = 497;
localparam int glyph_pitch = 14;
localparam int time_digit_x [4] = '{94, 108, 136, 150};
localparam int time_colon_x = 122;
localparam int move_digit_x [4] = '{581, 595, 609, 623};

//////////////////////////////
// Pegs and disks
localparam int peg_count = 3;
localparam int disks_per_peg = 10;
// Left edge of each 200 pixel peg column
localparam int peg_x [3] = '{5, 220, 435};
localparam int disk_w = 200;
localparam int disk_h = 20;
localparam int disk_pitch = 30;
// Slot 0 sits at the bottom, higher slots go up the screen
localparam int disk_base_y = 430;

//////////////////////////////
// Types
typedef logic [3:0] digit_t;

// Zero marks an empty slot
typedef logic [3:0] disk_size_t;

typedef struct packed {
	digit_t [3:0] time_digits;
	digit_t [3:0] move_digits;
	disk_size_t [peg_count-1:0][disks_per_peg-1:0] pegs;
} scene_t;

// Bit i drives pixel column i
typedef logic [screen_w-1:0] line_t;

endpackage

`default_nettype wire

//--- include/glyph_font.svh
`ifndef glyph_font_svh
`define glyph_font_svh

// Codes 0 to 9 are the decimal digits
localparam logic [4:0] g_t = 5'd10;
localparam logic [4:0] g_i = 5'd11;
localparam logic [4:0] g_m = 5'd12;
localparam logic [4:0] g_e = 5'd13;
localparam logic [4:0] g_o = 5'd14;
localparam logic [4:0] g_v = 5'd15;
localparam logic [4:0] g_colon = 5'd16;

localparam int glyph_count = 17;

// 3x6 patterns
// Pattern row 0 (top) sits in bits 17:15, row 5 in bits 2:0
// Within a row the msb is the leftmost column
localparam logic [17:0] glyph_font [glyph_count] = '{
	18'b111_101_101_101_111_000,
	18'b010_110_010_010_111_000,
	18'b111_001_111_100_111_000,
	18'b111_001_111_001_111_000,
	18'b101_101_111_001_001_000,
	18'b111_100_111_001_111_000,
	18'b111_100_111_101_111_000,
	18'b111_001_001_010_010_000,
	18'b111_101_111_101_111_000,
	18'b111_101_111_001_111_000,
	// T
	18'b111_010_010_010_010_000,
	// I
	18'b111_010_010_010_111_000,
	// M
	18'b101_111_111_101_101_000,
	// E
	18'b111_100_111_100_111_000,
	// O
	18'b010_101_101_101_010_000,
	// V
	18'b101_101_101_101_010_000,
	// Colon
	18'b000_010_000_010_000_000
};

`endif
